//--- vlog.f
+incdir+hdl
hdl/simf_isa_pkg.sv
hdl/simf_pipe_pkg.sv
hdl/simf_decode.sv
hdl/simf_execute.sv
hdl/simf_result.sv
hdl/simf_alu.sv
test/simf_alu_tb.sv

//--- Bender.yml
package:
  name: simf_alu

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/simf_isa_pkg.sv
      - hdl/simf_pipe_pkg.sv
      - hdl/simf_decode.sv
      - hdl/simf_execute.sv
      - hdl/simf_result.sv
      - hdl/simf_alu.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - test/simf_alu_tb.sv

//--- test/simf_alu_tb.sv
`include "simf_config.svh"

module simf_alu_tb import simf_isa_pkg::*, simf_pipe_pkg::*;;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int NUM_ISSUES  = 600;
   localparam int CYCLE_LIMIT = NUM_ISSUES * 20;
   localparam int MIN_LATENCY = 5; // Drive edge to the edge that samples result_valid_o

   logic       clk;
   logic       arst_n_i;
   logic       issue_valid_i;
   logic [31:0] instr_i;
   simf_word_t src_a_i;
   simf_word_t src_b_i;
   logic       vcc_i;
   logic       exec_i;
   logic       in_credit_o;
   logic       result_valid_o;
   simf_word_t vgpr_data_o;
   logic       vgpr_we_o;
   logic       vcc_o;
   logic       out_credit_i;

   simf_word_t exp_data [$];
   logic       exp_we [$];
   logic       exp_vcc [$];
   int         exp_cycle [$];
   int         cycle;
   int         issued;
   int         received;
   int         in_credits;
   int         avail; // Output credits the DUT holds at the sampling edge
   int         owed;  // Results received and not yet credited back
   int         delay;
   int         errors;
   int         mismatches;
   logic [2:0] ret_hist;
   logic       drained;

   simf_alu dut_i
      (
      .clk            (clk),
      .arst_n_i       (arst_n_i),
      .issue_valid_i  (issue_valid_i),
      .instr_i        (instr_i),
      .src_a_i        (src_a_i),
      .src_b_i        (src_b_i),
      .vcc_i          (vcc_i),
      .exec_i         (exec_i),
      .in_credit_o    (in_credit_o),
      .result_valid_o (result_valid_o),
      .vgpr_data_o    (vgpr_data_o),
      .vgpr_we_o      (vgpr_we_o),
      .vcc_o          (vcc_o),
      .out_credit_i   (out_credit_i)
      );

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic logic base_cond(input int c, input simf_word_t a, input simf_word_t b);
      case (c)
         1       : return a < b;
         2       : return a == b;
         3       : return a <= b;
         4       : return a > b;
         5       : return a != b;
         6       : return a >= b;
         default : return 1'b0; // F
      endcase
   endfunction

   // Expected write value, write enable and VCC for one issue
   function automatic void predict(input logic [31:0] instr, input simf_word_t a,
                                   input simf_word_t b, input logic vcc, input logic exec,
                                   output simf_word_t data, output logic we,
                                   output logic vcc_out);
      int fmt;
      int op;
      fmt     = instr[31:24];
      op      = instr[11:0];
      data    = '0;
      we      = 1'b0;
      vcc_out = vcc;
      if (exec && (fmt == 3 || fmt == 4) && op < 16 && op != 7 && op != 8)
         vcc_out = (op < 7) ? base_cond(op, a, b) : !base_cond(15 - op, a, b);
      else if (exec && fmt == 2 && op == 'h010)
      begin
         data = (a > b) ? a : b;
         we   = 1'b1;
      end
   endfunction

   function automatic int pick_delay();
      if ($urandom_range(0, 31) == 0)
         return $urandom_range(40, 120); // Long starvation
      return $urandom_range(0, 4);
   endfunction

   task automatic check_data(input simf_word_t got, input simf_word_t exp, input string what);
      if (got !== exp)
      begin
         mismatches++;
         $display("Mismatch at %0d ns: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_bit(input logic got, input logic exp, input string what);
      if (got !== exp)
      begin
         mismatches++;
         $display("Mismatch at %0d ns: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   // First 64 issues sweep every code of both compare formats with and without equal sources
   task automatic issue_instruction(input int idx);
      logic [7:0]  fmt;
      logic [11:0] op;
      simf_word_t  a;
      simf_word_t  b;
      logic        exec;
      logic        vcc;
      logic [31:0] instr;
      simf_word_t  data;
      logic        we;
      logic        vcc_out;
      int          r;
      r    = $urandom_range(0, 99);
      fmt  = $urandom_range(0, 1) ? FMT_VOP3A : FMT_VOPC;
      op   = $urandom_range(0, 15);
      if (idx < 64)
      begin
         fmt = idx[5] ? FMT_VOP3A : FMT_VOPC;
         op  = idx[3:0];
      end
      else if (r < 65 && r >= 45)
      begin
         fmt = FMT_VOP2;
         op  = SIMF_OP_MAX;
      end
      else if (r < 75 && r >= 65)
      begin
         fmt = FMT_VOP2;
         op  = $urandom;
      end
      else if (r < 85 && r >= 75)
         fmt = $urandom;
      else if (r >= 85)
         op = $urandom; // Opcodes out of the compare range
      a     = $urandom;
      b     = $urandom;
      if ((idx < 64) ? idx[4] : ($urandom_range(0, 3) == 0))
         b = a;
      exec  = (idx < 64) ? 1'b1 : ($urandom_range(0, 7) != 0);
      vcc   = $urandom_range(0, 1);
      instr = {fmt, 12'($urandom), op};
      issue_valid_i <= 1'b1;
      instr_i       <= instr;
      src_a_i       <= a;
      src_b_i       <= b;
      vcc_i         <= vcc;
      exec_i        <= exec;
      predict(instr, a, b, vcc, exec, data, we, vcc_out);
      exp_data.push_back(data);
      exp_we.push_back(we);
      exp_vcc.push_back(vcc_out);
      exp_cycle.push_back(cycle);
   endtask

   task automatic check_result();
      int lat;
      if (exp_data.size() == 0)
      begin
         errors++;
         $display("Error at %0d ns: a result arrived with no instruction pending", $time);
      end
      else
      begin
         check_data(vgpr_data_o, exp_data.pop_front(), $sformatf("result %0d data", received));
         check_bit(vgpr_we_o, exp_we.pop_front(), $sformatf("result %0d we", received));
         check_bit(vcc_o, exp_vcc.pop_front(), $sformatf("result %0d vcc", received));
         lat = cycle - exp_cycle.pop_front();
         if (lat < MIN_LATENCY)
         begin
            errors++;
            $display("Error at %0d ns: result %0d came %0d cycles after issue", $time,
                     received, lat);
         end
      end
      received++;
      owed++;
      if (avail == 0)
      begin
         errors++;
         $display("Error at %0d ns: a result was sent with no output credit", $time);
      end
      else
         avail--;
   endtask

   // One clock edge of issuer, consumer and checker
   task automatic clock_step();
      logic returned;
      returned      = 1'b0;
      issue_valid_i <= 1'b0;
      out_credit_i  <= 1'b0;
      if ($isunknown({result_valid_o, vgpr_we_o, in_credit_o}))
      begin
         errors++;
         $display("Error at %0d ns: result_valid_o, vgpr_we_o or in_credit_o is unknown",
                  $time);
      end
      if ((in_credit_o !== result_valid_o) || (vgpr_we_o && !result_valid_o))
      begin
         errors++;
         $display("Error at %0d ns: in_credit_o or vgpr_we_o high without a result", $time);
      end
      avail += ret_hist[2]; // Credit returned three edges ago
      if (result_valid_o)
         check_result();
      if (in_credit_o)
         in_credits++;
      if (in_credits > `SIMF_QUEUE_DEPTH)
      begin
         errors++;
         $display("Error at %0d ns: more input credits returned than issued", $time);
         in_credits = `SIMF_QUEUE_DEPTH;
      end
      if (issued < NUM_ISSUES && in_credits > 0 && $urandom_range(0, 3) != 0)
      begin
         issue_instruction(issued);
         issued++;
         in_credits--;
      end
      if (owed > 0 && delay == 0)
      begin
         out_credit_i <= 1'b1;
         owed--;
         returned = 1'b1;
         delay    = pick_delay();
      end
      else if (owed > 0)
         delay--;
      ret_hist = {ret_hist[1:0], returned};
   endtask

   initial
   begin
      void'($urandom(32'h6868f7c2));
      arst_n_i      = 1'b0;
      issue_valid_i = 1'b0;
      instr_i       = '0;
      src_a_i       = '0;
      src_b_i       = '0;
      vcc_i         = 1'b0;
      exec_i        = 1'b0;
      out_credit_i  = 1'b0;
      cycle         = 0;
      issued        = 0;
      received      = 0;
      in_credits    = `SIMF_QUEUE_DEPTH;
      avail         = `SIMF_OUT_CREDITS;
      owed          = 0;
      delay         = 0;
      errors        = 0;
      mismatches    = 0;
      ret_hist      = '0;
      drained       = 1'b0;
      repeat (16) @(posedge clk);
      arst_n_i <= 1'b1;
      while (!drained && cycle < CYCLE_LIMIT)
      begin
         @(posedge clk);
         cycle++;
         clock_step();
         drained = (issued == NUM_ISSUES) && (exp_data.size() == 0) &&
                   (in_credits == `SIMF_QUEUE_DEPTH);
      end
      if (!drained)
      begin
         errors++;
         $display("Timeout after %0d cycles: %0d results missing, %0d instructions not issued",
                  cycle, exp_data.size(), NUM_ISSUES - issued);
      end
      $display("%0d results checked, %0d mismatches, %0d other errors", received, mismatches,
               errors);
      if (errors == 0 && mismatches == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

//--- hdl/simf_alu.sv
module simf_alu
   import simf_isa_pkg::*, simf_pipe_pkg::*;
   (
   input  logic        clk,
   input  logic        arst_n_i,
   input  logic        issue_valid_i,
   input  logic [31:0] instr_i,
   input  simf_word_t  src_a_i,
   input  simf_word_t  src_b_i,
   input  logic        vcc_i,
   input  logic        exec_i,
   output logic        in_credit_o,
   output logic        result_valid_o,
   output simf_word_t  vgpr_data_o,
   output logic        vgpr_we_o,
   output logic        vcc_o,
   input  logic        out_credit_i
   );

   logic       dec_valid;
   simf_kind_e dec_kind;
   simf_cond_e dec_cond;
   simf_word_t dec_src_a;
   simf_word_t dec_src_b;
   logic       dec_vcc;

   logic       ex_valid;
   simf_word_t ex_data;
   logic       ex_we;
   logic       ex_vcc;

   simf_decode decode_i
      (
      .clk           (clk),
      .arst_n_i      (arst_n_i),
      .issue_valid_i (issue_valid_i),
      .instr_i       (instr_i),
      .src_a_i       (src_a_i),
      .src_b_i       (src_b_i),
      .vcc_i         (vcc_i),
      .exec_i        (exec_i),
      .valid_o       (dec_valid),
      .kind_o        (dec_kind),
      .cond_o        (dec_cond),
      .src_a_o       (dec_src_a),
      .src_b_o       (dec_src_b),
      .vcc_o         (dec_vcc)
      );

   simf_execute execute_i
      (
      .clk      (clk),
      .arst_n_i (arst_n_i),
      .valid_i  (dec_valid),
      .kind_i   (dec_kind),
      .cond_i   (dec_cond),
      .src_a_i  (dec_src_a),
      .src_b_i  (dec_src_b),
      .vcc_i    (dec_vcc),
      .valid_o  (ex_valid),
      .data_o   (ex_data),
      .we_o     (ex_we),
      .vcc_o    (ex_vcc)
      );

   simf_result result_i
      (
      .clk            (clk),
      .arst_n_i       (arst_n_i),
      .valid_i        (ex_valid),
      .data_i         (ex_data),
      .we_i           (ex_we),
      .vcc_i          (ex_vcc),
      .out_credit_i   (out_credit_i),
      .result_valid_o (result_valid_o),
      .vgpr_data_o    (vgpr_data_o),
      .vgpr_we_o      (vgpr_we_o),
      .vcc_o          (vcc_o),
      .in_credit_o    (in_credit_o)
      );

endmodule

//--- hdl/simf_result.sv
`include "simf_config.svh"

module simf_result
   import simf_pipe_pkg::*;
   (
   input  logic       clk,
   input  logic       arst_n_i,
   input  logic       valid_i,
   input  simf_word_t data_i,
   input  logic       we_i,
   input  logic       vcc_i,
   input  logic       out_credit_i,
   output logic       result_valid_o,
   output simf_word_t vgpr_data_o,
   output logic       vgpr_we_o,
   output logic       vcc_o,
   output logic       in_credit_o
   );

   simf_word_t data_mem [`SIMF_QUEUE_DEPTH];
   logic       we_mem   [`SIMF_QUEUE_DEPTH];
   logic       vcc_mem  [`SIMF_QUEUE_DEPTH];

   simf_ptr_t    wr_ptr_q;
   simf_ptr_t    rd_ptr_q;
   simf_credit_t credit_q;
   logic [$clog2(`SIMF_QUEUE_DEPTH):0] count_q;
   logic         send;

   assign send = (count_q != '0) && (credit_q != '0);

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         wr_ptr_q       <= '0;
         rd_ptr_q       <= '0;
         count_q        <= '0;
         credit_q       <= simf_credit_t'(`SIMF_OUT_CREDITS);
         result_valid_o <= 1'b0;
         vgpr_we_o      <= 1'b0;
         in_credit_o    <= 1'b0;
      end
      else
      begin
         if (valid_i)
            wr_ptr_q <= wr_ptr_q + 1'b1;
         if (send)
            rd_ptr_q <= rd_ptr_q + 1'b1;
         case ({valid_i, send})
            2'b10   : count_q <= count_q + 1'b1;
            2'b01   : count_q <= count_q - 1'b1;
            default : count_q <= count_q;
         endcase
         case ({out_credit_i, send})
            2'b10   : credit_q <= credit_q + 1'b1;
            2'b01   : credit_q <= credit_q - 1'b1;
            default : credit_q <= credit_q;
         endcase
         result_valid_o <= send;
         vgpr_we_o      <= send && we_mem[rd_ptr_q];
         in_credit_o    <= send; // Freed slot back to issuer
      end
   end

   always_ff @(posedge clk)
   begin
      if (valid_i)
      begin
         data_mem[wr_ptr_q] <= data_i;
         we_mem[wr_ptr_q]   <= we_i;
         vcc_mem[wr_ptr_q]  <= vcc_i;
      end
      if (send)
      begin
         vgpr_data_o <= data_mem[rd_ptr_q];
         vcc_o       <= vcc_mem[rd_ptr_q];
      end
   end

   // Issue credits must keep the queue from overflowing
   a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n_i)
      valid_i |-> (count_q != `SIMF_QUEUE_DEPTH));

   a_credit_max: assert property (@(posedge clk) disable iff (!arst_n_i)
      credit_q <= `SIMF_OUT_CREDITS);

endmodule

//--- hdl/simf_execute.sv
module simf_execute
   import simf_isa_pkg::*, simf_pipe_pkg::*;
   (
   input  logic       clk,
   input  logic       arst_n_i,
   input  logic       valid_i,
   input  simf_kind_e kind_i,
   input  simf_cond_e cond_i,
   input  simf_word_t src_a_i,
   input  simf_word_t src_b_i,
   input  logic       vcc_i,
   output logic       valid_o,
   output simf_word_t data_o,
   output logic       we_o,
   output logic       vcc_o
   );

   logic       lt;
   logic       eq;
   logic       gt;
   logic       cmp;
   simf_word_t max;

   // Unsigned word compares
   assign lt  = src_a_i < src_b_i;
   assign eq  = src_a_i == src_b_i;
   assign gt  = src_a_i > src_b_i;
   assign max = (src_a_i >= src_b_i) ? src_a_i : src_b_i;

   always_comb
   begin
      case (cond_i)
         COND_F   : cmp = 1'b0;
         COND_LT  : cmp = lt;
         COND_EQ  : cmp = eq;
         COND_LE  : cmp = lt | eq;
         COND_GT  : cmp = gt;
         COND_LG  : cmp = !eq;
         COND_GE  : cmp = !lt;
         COND_NGE : cmp = lt;
         COND_NLG : cmp = eq;
         COND_NGT : cmp = !gt;
         COND_NLE : cmp = gt;
         COND_NEQ : cmp = !eq;
         COND_NLT : cmp = !lt;
         COND_TRU : cmp = 1'b1;
         default  : cmp = vcc_i; // Filtered out by decode
      endcase
   end

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
         valid_o <= 1'b0;
      else
         valid_o <= valid_i;
   end

   always_ff @(posedge clk)
   begin
      if (valid_i)
      begin
         data_o <= (kind_i == KIND_MAX) ? max : '0;
         we_o   <= (kind_i == KIND_MAX);
         vcc_o  <= (kind_i == KIND_CMP) ? cmp : vcc_i; // Compare replaces VCC
      end
   end

   // Decode only ever issues the three defined kinds
   a_kind_known: assert property (@(posedge clk) disable iff (!arst_n_i)
      valid_i |-> (kind_i inside {KIND_NOP, KIND_CMP, KIND_MAX}));

endmodule

//--- hdl/simf_decode.sv
module simf_decode
   import simf_isa_pkg::*, simf_pipe_pkg::*;
   (
   input  logic        clk,
   input  logic        arst_n_i,
   input  logic        issue_valid_i,
   input  logic [31:0] instr_i,
   input  simf_word_t  src_a_i,
   input  simf_word_t  src_b_i,
   input  logic        vcc_i,
   input  logic        exec_i,
   output logic        valid_o,
   output simf_kind_e  kind_o,
   output simf_cond_e  cond_o,
   output simf_word_t  src_a_o,
   output simf_word_t  src_b_o,
   output logic        vcc_o
   );

   simf_fmt_e    fmt;
   simf_opcode_t opcode;
   simf_kind_e   kind;
   logic         is_cmp_fmt;
   logic         cond_known;

   assign fmt    = simf_fmt_e'(instr_i[31:24]);
   assign opcode = instr_i[$bits(simf_opcode_t)-1:0];

   assign is_cmp_fmt = (fmt == FMT_VOPC) || (fmt == FMT_VOP3A);
   assign cond_known = (opcode[$bits(simf_opcode_t)-1:4] == '0) &&
                       (opcode[3:0] != 4'd7) && (opcode[3:0] != 4'd8);

   always_comb
   begin
      kind = KIND_NOP; // Disabled lane or unknown op
      if (exec_i)
      begin
         if (is_cmp_fmt && cond_known)
            kind = KIND_CMP;
         else if ((fmt == FMT_VOP2) && (opcode == SIMF_OP_MAX))
            kind = KIND_MAX;
      end
   end

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
         valid_o <= 1'b0;
      else
         valid_o <= issue_valid_i;
   end

   always_ff @(posedge clk)
   begin
      if (issue_valid_i)
      begin
         kind_o  <= kind;
         cond_o  <= simf_cond_e'(opcode[3:0]); // Only read for CMP
         src_a_o <= src_a_i;
         src_b_o <= src_b_i;
         vcc_o   <= vcc_i;
      end
   end

endmodule

//--- hdl/simf_pipe_pkg.sv
`include "simf_config.svh"

package simf_pipe_pkg;

   // One lane data word
   typedef logic [`SIMF_DATA_W-1:0] simf_word_t;

   // Output credit count, wide enough for the reset grant
   typedef logic [2:0] simf_credit_t;

   // Result queue index
   typedef logic [$clog2(`SIMF_QUEUE_DEPTH)-1:0] simf_ptr_t;

endpackage

//--- hdl/simf_isa_pkg.sv
`include "simf_config.svh"

package simf_isa_pkg;

   // Format field, bits 31:24 of the instruction
   typedef enum logic [7:0]
   {
      FMT_VOP1  = 8'd1,
      FMT_VOP2  = 8'd2,
      FMT_VOPC  = 8'd3,
      FMT_VOP3A = 8'd4
   } simf_fmt_e;

   typedef logic [`SIMF_OP_W-1:0] simf_opcode_t;

   // Compare conditions as encoded in the low opcode bits
   typedef enum logic [3:0]
   {
      COND_F   = 4'd0,
      COND_LT  = 4'd1,
      COND_EQ  = 4'd2,
      COND_LE  = 4'd3,
      COND_GT  = 4'd4,
      COND_LG  = 4'd5,
      COND_GE  = 4'd6,
      COND_NGE = 4'd9,  // 7 and 8 are not assigned
      COND_NLG = 4'd10,
      COND_NGT = 4'd11,
      COND_NLE = 4'd12,
      COND_NEQ = 4'd13,
      COND_NLT = 4'd14,
      COND_TRU = 4'd15
   } simf_cond_e;

   // What the execute stage does with an item
   typedef enum logic [1:0]
   {
      KIND_NOP = 2'd0,
      KIND_CMP = 2'd1,
      KIND_MAX = 2'd2
   } simf_kind_e;

   // V_MAX_F32 in VOP2
   localparam simf_opcode_t SIMF_OP_MAX = simf_opcode_t'('h010);

endpackage

//--- hdl/simf_config.svh
`ifndef SIMF_CONFIG_SVH
`define SIMF_CONFIG_SVH

// Lane operand width
`define SIMF_DATA_W 32

// Opcode field, bits 11:0 of the instruction
`define SIMF_OP_W 12

// Result queue entries, equal to the issuer's starting credits
`define SIMF_QUEUE_DEPTH 4

// Credits granted by the consumer at reset
`define SIMF_OUT_CREDITS 2

`endif
